//--- design/uart_pkg.sv
`default_nettype none

package uart_pkg;

   // one data byte of a frame
   typedef logic [7:0] byte_t;

   // command word, high byte goes out first
   typedef logic [15:0] cmd_t;

   // start, eight data, parity, stop
   localparam int frame_bits = 11;

   // position within the two frames of a command (0 to 21)
   typedef logic [4:0] bit_idx_t;

   typedef struct packed {
      byte_t data;
      logic  err;
   } rx_byte_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_shift,
      tx_done
   } tx_state_t;

   typedef enum logic [2:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_parity,
      rx_stop
   } rx_state_t;

endpackage

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
   parameter int clks_per_bit = 8
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               rx,
   output uart_pkg::rx_byte_t rx_byte,
   output logic               rx_vld
);

   localparam int cnt_w    = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam int half_cnt = (clks_per_bit / 2 > 0) ? clks_per_bit / 2 - 1 : 0;

   typedef logic [cnt_w-1:0] baud_cnt_t;

   uart_pkg::rx_state_t state;
   baud_cnt_t           baud_cnt;
   logic [2:0]          data_idx;
   logic                rx_meta;
   logic                rx_sync;
   logic                rx_prev;
   logic                start_edge;
   logic                mid_start;
   logic                bit_end;
   uart_pkg::byte_t     sh_data;
   logic                par_bit;
   logic                frame_err;

   // two-flop synchronizer plus one flop for edge detection
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign start_edge = rx_prev & ~rx_sync;
   assign mid_start  = (baud_cnt == baud_cnt_t'(half_cnt));
   assign bit_end    = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

   // parity fault or a low stop bit, checked as the stop bit is sampled
   assign frame_err = ~(^{sh_data, par_bit}) | ~rx_sync;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= uart_pkg::rx_idle;
         baud_cnt <= '0;
         data_idx <= '0;
         rx_byte  <= '0;
         rx_vld   <= 1'b0;
      end else begin
         rx_vld <= 1'b0;
         case (state)
            uart_pkg::rx_idle: begin
               if (start_edge) begin
                  state    <= uart_pkg::rx_start;
                  baud_cnt <= '0;
               end
            end
            uart_pkg::rx_start: begin
               if (mid_start) begin
                  baud_cnt <= '0;
                  data_idx <= '0;
                  // start bit gone high again, treat as a glitch
                  if (rx_sync) begin
                     state <= uart_pkg::rx_idle;
                  end else begin
                     state <= uart_pkg::rx_data;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_pkg::rx_data: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  data_idx <= data_idx + 1'b1;
                  if (data_idx == 3'd7) begin
                     state <= uart_pkg::rx_parity;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_pkg::rx_parity: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  state    <= uart_pkg::rx_stop;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_pkg::rx_stop: begin
               if (bit_end) begin
                  baud_cnt     <= '0;
                  state        <= uart_pkg::rx_idle;
                  rx_byte.data <= sh_data;
                  rx_byte.err  <= frame_err;
                  rx_vld       <= 1'b1;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               state <= uart_pkg::rx_idle;
            end
         endcase
      end
   end

   // mid-bit samples, data arrives lsb first
   always_ff @(posedge clk) begin
      if (bit_end && state == uart_pkg::rx_data) begin
         sh_data <= {rx_sync, sh_data[7:1]};
      end
      if (bit_end && state == uart_pkg::rx_parity) begin
         par_bit <= rx_sync;
      end
   end

endmodule

`default_nettype wire

//--- design/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top #(
   parameter int clks_per_bit = 8
) (
   input  logic            clk,
   input  logic            rst_n,
   input  uart_pkg::cmd_t  cmd_in,
   input  logic            cmd_vld,
   output logic            cmd_rdy,
   output logic            tx,
   input  logic            rx,
   output uart_pkg::byte_t read_data,
   output logic            read_rdy,
   output logic            read_err
);

   uart_pkg::rx_byte_t rx_byte;
   logic               rx_vld;

   uart_tx #(
      .clks_per_bit (clks_per_bit)
   ) u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   uart_rx #(
      .clks_per_bit (clks_per_bit)
   ) u_rx (
      .clk     (clk),
      .rst_n   (rst_n),
      .rx      (rx),
      .rx_byte (rx_byte),
      .rx_vld  (rx_vld)
   );

   // receive result split onto the read port
   assign read_data = rx_byte.data;
   assign read_err  = rx_byte.err;
   assign read_rdy  = rx_vld;

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
   parameter int clks_per_bit = 8
) (
   input  logic           clk,
   input  logic           rst_n,
   input  uart_pkg::cmd_t cmd_in,
   input  logic           cmd_vld,
   output logic           cmd_rdy,
   output logic           tx
);

   localparam int cnt_w     = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam int line_bits = 2 * uart_pkg::frame_bits;

   typedef logic [cnt_w-1:0]     baud_cnt_t;
   typedef logic [line_bits-1:0] line_t;

   uart_pkg::tx_state_t state;
   baud_cnt_t           baud_cnt;
   uart_pkg::bit_idx_t  bit_idx;
   line_t               shreg;
   line_t               frames;
   uart_pkg::byte_t     hi_byte;
   uart_pkg::byte_t     lo_byte;
   logic                par_hi;
   logic                par_lo;
   logic                bit_end;

   assign hi_byte = cmd_in[15:8];
   assign lo_byte = cmd_in[7:0];

   // odd parity, ones in data plus parity come out odd
   assign par_hi = ~^hi_byte;
   assign par_lo = ~^lo_byte;

   // line order is bit 0 first, so the high-byte frame sits in the low bits
   assign frames = {1'b1, par_lo, lo_byte, 1'b0,
                    1'b1, par_hi, hi_byte, 1'b0};

   assign bit_end = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

   assign cmd_rdy = (state == uart_pkg::tx_idle);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= uart_pkg::tx_idle;
         baud_cnt <= '0;
         bit_idx  <= '0;
         tx       <= 1'b1;
      end else begin
         case (state)
            uart_pkg::tx_idle: begin
               if (cmd_vld) begin
                  // start bit of the high frame goes out right away
                  state    <= uart_pkg::tx_shift;
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  tx       <= frames[0];
               end
            end
            uart_pkg::tx_shift: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  bit_idx  <= bit_idx + 1'b1;
                  tx       <= shreg[1];
                  // next bit is the final stop bit
                  if (bit_idx == uart_pkg::bit_idx_t'(line_bits - 2)) begin
                     state <= uart_pkg::tx_done;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_pkg::tx_done: begin
               if (bit_end) begin
                  state    <= uart_pkg::tx_idle;
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  tx       <= 1'b1;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               state <= uart_pkg::tx_idle;
               tx    <= 1'b1;
            end
         endcase
      end
   end

   // frames load while idle, shift right once per bit
   always_ff @(posedge clk) begin
      if (state == uart_pkg::tx_idle) begin
         shreg <= frames;
      end else if (bit_end) begin
         shreg <= {1'b1, shreg[line_bits-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- flist.f
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
verification/uart_assertions.sv
verification/uart_checker.sv
verification/uart_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the uart testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module uart_tb -f flist.f -o uart_sim > build.log 2>&1 \
   && ./obj_dir/uart_sim > "$log" 2>&1 \
   && cat "$log" \
   && ! grep -qF "*** TEST FAILED ***" "$log" \
   && echo "simulation passed" \
   || { cat build.log "$log" 2>/dev/null; echo "simulation failed"; exit 1; }

//--- verification/uart_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module uart_assertions #(
   parameter int clks_per_bit = 8
) (
   input logic clk,
   input logic rst_n,
   input logic cmd_rdy,
   input logic tx,
   input logic rx_vld
);

   int low_cnt;

   // cycles seen with cmd_rdy low in the current busy stretch
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         low_cnt <= 0;
      end else if (cmd_rdy) begin
         low_cnt <= 0;
      end else begin
         low_cnt <= low_cnt + 1;
      end
   end

   idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
      else $error("tx low while the transmitter is idle");

   single_cycle_vld: assert property (@(posedge clk) disable iff (!rst_n) rx_vld |=> !rx_vld)
      else $error("rx_vld high in two consecutive cycles");

   busy_length: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cmd_rdy) |-> (low_cnt == 22 * clks_per_bit))
      else $error("cmd_rdy low for %0d cycles", low_cnt);

endmodule

// one instance at the top level sees both the transmitter and the receiver
bind uart_top uart_assertions #(.clks_per_bit(clks_per_bit)) props (
   .clk     (clk),
   .rst_n   (rst_n),
   .cmd_rdy (cmd_rdy),
   .tx      (tx),
   .rx_vld  (rx_vld)
);

`default_nettype wire

//--- verification/uart_checker.sv
`timescale 1ns/100ps
`default_nettype none

module uart_checker #(
   parameter int clks_per_bit = 8
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            cmd_vld,
   input  logic            cmd_rdy,
   input  logic            tx,
   input  uart_pkg::byte_t read_data,
   input  logic            read_rdy,
   input  logic            read_err,
   output int              errors,
   output int              checks,
   output int              pending
);

   localparam int busy_cycles = 22 * clks_per_bit;
   localparam int reset_wait  = 100;

   // expected read port results, data in bits 8:1 and err in bit 0
   logic [8:0]      exp_rd[$];
   uart_pkg::byte_t exp_tx[$];

   task automatic fail_value(input string msg);
      errors = errors + 1;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   task automatic load_expectations();
      int    fd;
      int    n;
      string line;
      logic [15:0] cmd;
      logic [7:0]  d;
      int    p;
      int    s;
      int    e;
      fd = $fopen("verification/uart_stimulus.txt", "r");
      if (fd == 0) begin
         errors = errors + 1;
         $display("checker could not open the stimulus file");
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n == 0 || line.len() == 0) continue;
         if (line[0] == "C") begin
            n = $sscanf(line, "C %h", cmd);
            exp_tx.push_back(cmd[15:8]);
            exp_tx.push_back(cmd[7:0]);
            exp_rd.push_back({cmd[15:8], 1'b0});
            exp_rd.push_back({cmd[7:0], 1'b0});
         end else if (line[0] == "F") begin
            n = $sscanf(line, "F %h %d %d %d", d, p, s, e);
            exp_rd.push_back({d, e[0]});
         end
      end
      $fclose(fd);
   endtask

   // one frame as decoded from tx, bit 0 is the start bit
   task automatic check_frame(input logic [10:0] fr);
      int ones;
      uart_pkg::byte_t want;
      ones = 0;
      for (int i = 1; i <= 9; i++) begin
         ones += fr[i];
      end
      checks = checks + 1;
      if (fr[0] !== 1'b0) fail_value("tx start bit not low");
      if (fr[10] !== 1'b1) fail_value("tx stop bit not high");
      if (ones % 2 != 1) fail_value($sformatf("tx parity wrong in frame %b", fr));
      if (exp_tx.size() == 0) begin
         fail_value($sformatf("tx sent unexpected byte %h", fr[8:1]));
      end else begin
         want = exp_tx.pop_front();
         if (fr[8:1] !== want) begin
            fail_value($sformatf("tx byte %h, expected %h", fr[8:1], want));
         end
      end
   endtask

   task automatic watch_command();
      int          cyc;
      logic [21:0] line_bits;
      bit          done;
      cyc  = 0;
      done = 0;
      line_bits = '0;
      while (!done) begin
         @(posedge clk);
         cyc++;
         if (cmd_rdy) begin
            done = 1;
         end else if (cyc > busy_cycles + 10) begin
            errors = errors + 1;
            $display("transmitter stayed busy far too long");
            done = 1;
         end else if (cyc % clks_per_bit == clks_per_bit / 2) begin
            line_bits[cyc / clks_per_bit] = tx;
         end
      end
      checks = checks + 1;
      if (cyc - 1 != busy_cycles) begin
         fail_value($sformatf("cmd_rdy low %0d cycles, expected %0d", cyc - 1, busy_cycles));
      end
      if (tx !== 1'b1) fail_value("tx not high when cmd_rdy returns");
      check_frame(line_bits[10:0]);
      check_frame(line_bits[21:11]);
   endtask

   initial begin
      int n;
      errors  = 0;
      checks  = 0;
      pending = 0;
      load_expectations();
      n = 0;
      while (rst_n !== 1'b1 && n <= reset_wait) begin
         @(posedge clk);
         n++;
      end
      if (rst_n !== 1'b1) begin
         errors = errors + 1;
         $display("reset was never released");
      end
      // first edge out of reset, still reset values here
      checks = checks + 1;
      if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0 ||
          read_err !== 1'b0 || read_data !== 8'h00) begin
         fail_value("outputs not at their reset values");
      end
      forever begin
         @(posedge clk);
         if (cmd_vld && cmd_rdy) watch_command();
      end
   end

   always @(posedge clk) begin
      if (rst_n && read_rdy) begin
         checks = checks + 1;
         if (exp_rd.size() == 0) begin
            fail_value($sformatf("unexpected read byte %h", read_data));
         end else if ({read_data, read_err} !== exp_rd[0]) begin
            fail_value($sformatf("read %h err %b, expected %h err %b", read_data,
                                 read_err, exp_rd[0][8:1], exp_rd[0][0]));
            void'(exp_rd.pop_front());
         end else begin
            void'(exp_rd.pop_front());
         end
      end
      pending <= exp_rd.size() + exp_tx.size();
   end

endmodule

`default_nettype wire

//--- verification/uart_stimulus.txt
# C cmd_hex : command word sent in loopback, expect high then low byte, err 0
# F data_hex parity stop err : raw frame driven on rx with its expected err
C A55A
C 0000
C FFFF
C 1234
F 3C 1 1 0
F 3C 0 1 1
F 81 1 0 1
F 7F 0 1 0
F 00 0 1 1
C 8001
C BEEF
C 0F0F

//--- verification/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tb;

   localparam int          cpb       = 8;
   localparam int          wait_max  = 2000;
   localparam logic [31:0] seed      = 32'h5fb4_1561;

   logic            clk;
   logic            rst_n;
   uart_pkg::cmd_t  cmd_in;
   logic            cmd_vld;
   logic            cmd_rdy;
   logic            tx;
   logic            rx_line;
   logic            rx_drv;
   logic            loop_sel;
   uart_pkg::byte_t read_data;
   logic            read_rdy;
   logic            read_err;
   int              rd_count;
   int              exp_reads;
   bit              timed_out;
   int              errors;
   int              checks;
   int              pending;

   always #20 clk = ~clk;

   // loopback from tx or the local line driver
   assign rx_line = loop_sel ? tx : rx_drv;

   uart_top #(.clks_per_bit(cpb)) uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .rx        (rx_line),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .read_err  (read_err)
   );

   uart_checker #(.clks_per_bit(cpb)) chk (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .read_err  (read_err),
      .errors    (errors),
      .checks    (checks),
      .pending   (pending)
   );

   always @(posedge clk) begin
      if (read_rdy) rd_count <= rd_count + 1;
   end

   task automatic wait_cmd_rdy();
      int n;
      n = 0;
      while (1) begin
         @(posedge clk);
         if (cmd_rdy) break;
         n++;
         if (n > wait_max) begin
            $display("timeout while waiting for cmd_rdy");
            timed_out = 1;
            break;
         end
      end
   endtask

   task automatic wait_reads(input int target);
      int n;
      n = 0;
      while (1) begin
         @(posedge clk);
         if (rd_count >= target) break;
         n++;
         if (n > wait_max) begin
            $display("timeout while waiting for read_rdy");
            timed_out = 1;
            break;
         end
      end
   endtask

   task automatic send_command(input uart_pkg::cmd_t cmd);
      wait_cmd_rdy();
      if (timed_out) return;
      cmd_in  <= cmd;
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
      repeat (20) @(posedge clk);
      // busy, so this one must be dropped
      cmd_in  <= ~cmd;
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
   endtask

   task automatic drive_frame(input uart_pkg::byte_t d, input logic p, input logic s);
      logic [10:0] bits;
      bits = {s, p, d, 1'b0};
      loop_sel <= 1'b0;
      for (int i = 0; i < 11; i++) begin
         rx_drv <= bits[i];
         repeat (cpb) @(posedge clk);
      end
      rx_drv <= 1'b1;
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      logic [15:0] cmd;
      logic [7:0]  d;
      int          p;
      int          s;
      clk       = 1'b0;
      rst_n     = 1'b0;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      rx_drv    = 1'b1;
      loop_sel  = 1'b1;
      rd_count  = 0;
      exp_reads = 0;
      timed_out = 0;
      n = $urandom(seed);
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      fd = $fopen("verification/uart_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file");
         timed_out = 1;
      end
      while (fd != 0 && !timed_out && !$feof(fd)) begin
         n = $fgets(line, fd);
         if (n == 0 || line.len() == 0) continue;
         if (line[0] == "C") begin
            n = $sscanf(line, "C %h", cmd);
            loop_sel  <= 1'b1;
            exp_reads += 2;
            send_command(cmd);
         end else if (line[0] == "F") begin
            n = $sscanf(line, "F %h %d %d", d, p, s);
            // line must be quiet before taking it over
            wait_reads(exp_reads);
            if (!timed_out) begin
               repeat ($urandom_range(6, 1)) @(posedge clk);
               exp_reads += 1;
               drive_frame(d, p[0], s[0]);
               wait_reads(exp_reads);
            end
         end
      end
      if (fd != 0) $fclose(fd);
      if (!timed_out) wait_cmd_rdy();
      if (!timed_out) wait_reads(exp_reads);
      repeat (4 * cpb) @(posedge clk);
      if (pending != 0) $display("%0d expected results never arrived", pending);
      $display("checks %0d, errors %0d, timeouts %0d, reads %0d", checks, errors,
               timed_out, rd_count);
      if (errors == 0 && !timed_out && pending == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
